//--- compile.f
logic/udp_pkg.sv
logic/frame_gen.sv
logic/udp_header_insert.sv
logic/axis_width_down.sv
logic/stream_fifo.sv
logic/axis_width_up.sv
logic/udp_frame_check.sv
logic/udp_loopback_top.sv
sim/tb_clk_gen.sv
sim/udp_loopback_tb.sv

//--- sim/udp_loopback_tb.sv
`timescale 1ns/1ps
module udp_loopback_tb
  import udp_pkg::*;
();

  localparam int N_FRAMES        = 30;
  localparam int TIMEOUT_CYCLES  = N_FRAMES * (MAX_PAYLOAD / 32 + 20) * 2;
  localparam int CORRUPT_NONE    = 0;
  localparam int CORRUPT_PAYLOAD = 1;
  localparam int CORRUPT_UDP_LEN = 2;

  typedef struct packed {
    logic [15:0] byte_num;
    logic        err;
    logic [15:0] err_cnt;
    logic [15:0] beats;  // link beats on the wire
  } status_t;

  logic                   pkt_clk;
  logic                   arst_n;
  logic                   cmd_req;
  logic [LEN_W-1:0]       cmd_len;
  logic                   cmd_ack;
  logic                   link_tx_valid;
  logic                   link_tx_ready;
  logic [LINK_W-1:0]      link_tx_data;
  logic [LINK_KEEP_W-1:0] link_tx_keep;
  logic                   link_tx_last;
  logic                   link_rx_valid;
  logic [LINK_W-1:0]      link_rx_data;
  logic [LINK_KEEP_W-1:0] link_rx_keep;
  logic                   link_rx_last;
  logic                   rx_done;
  logic [LEN_W-1:0]       rx_byte_num;
  logic                   rx_error;
  logic [LEN_W-1:0]       rx_error_cnt;

  status_t exp_q[$];
  int      beat_q[$];
  int      tx_len_q[$];  // payload length of each frame not yet seen on tx
  int      seed = 30692;
  int      rand_len[20];
  int      cycles, n_errors, n_checks, n_tests, test_err_start;
  int      frame_idx, sent_cnt, done_cnt, err_total;
  int      tx_frame, tx_beat;
  int      corrupt_frame = -1;
  int      corrupt_kind = CORRUPT_NONE;
  int      corrupt_pos;
  logic    rand_ready;
  logic    acked_early;
  string   cur_test;

  tb_clk_gen clk_gen_i (.pkt_clk(pkt_clk), .arst_n(arst_n));

  udp_loopback_top udp_loopback_top_i (
    .pkt_clk(pkt_clk), .arst_n(arst_n),
    .cmd_req(cmd_req), .cmd_len(cmd_len), .cmd_ack(cmd_ack),
    .link_tx_valid(link_tx_valid), .link_tx_ready(link_tx_ready),
    .link_tx_data(link_tx_data), .link_tx_keep(link_tx_keep), .link_tx_last(link_tx_last),
    .link_rx_valid(link_rx_valid), .link_rx_data(link_rx_data),
    .link_rx_keep(link_rx_keep), .link_rx_last(link_rx_last),
    .rx_done(rx_done), .rx_byte_num(rx_byte_num), .rx_error(rx_error),
    .rx_error_cnt(rx_error_cnt)
  );

  // expected status from the payload pattern and header rules
  function automatic status_t ref_status(input int len, input int frame, input int kind,
                                         input int pos);
    status_t     s;
    logic [7:0]  good;
    logic [15:0] udp_field;
    s.byte_num = 16'(len);
    s.beats    = 16'(2 + (len + 31) / 32);  // header takes two link beats
    s.err      = 1'b0;
    if (kind == CORRUPT_PAYLOAD && pos < len) begin
      good  = 8'((frame + pos) % 256);
      s.err = ((good ^ 8'hff) != good);
    end
    if (kind == CORRUPT_UDP_LEN) begin
      udp_field = 16'(len + 8) ^ 16'hff00;  // high byte comes first on the wire
      s.err     = (udp_field != 16'(len + 8));
    end
    s.err_cnt = 16'(err_total) + 16'(s.err);
    return s;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("Mismatch %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
    end
  endtask

  task automatic start_test(input string name);
    cur_test       = name;
    test_err_start = n_errors;
  endtask

  task automatic report_test();
    n_tests++;
    if (n_errors == test_err_start)
      $display("test %s: ok", cur_test);
    else
      $display("test %s: %0d errors", cur_test, n_errors - test_err_start);
  endtask

  task automatic expect_frame(input int len, input int kind, input int pos);
    status_t s;
    if (kind != CORRUPT_NONE) begin
      corrupt_frame = frame_idx;
      corrupt_kind  = kind;
      corrupt_pos   = pos;
    end
    s = ref_status(len, frame_idx, kind, pos);
    err_total = s.err_cnt;
    exp_q.push_back(s);
    tx_len_q.push_back(len);
    frame_idx++;
    sent_cnt++;
  endtask

  // sends a four-phase command from 1 ns after an edge
  task automatic issue_frame(input int len, input int kind, input int pos);
    expect_frame(len, kind, pos);
    cmd_len = LEN_W'(len);
    cmd_req = 1'b1;
    @(posedge pkt_clk);
    #1;
    while (!cmd_ack) begin
      @(posedge pkt_clk);
      #1;
    end
    cmd_req = 1'b0;
    while (cmd_ack) begin
      @(posedge pkt_clk);
      #1;
    end
  endtask

  task automatic wait_frames();
    while (done_cnt < sent_cnt) @(posedge pkt_clk);
    #1;
  endtask

  // tx link beat against keep rules, udp length field and payload pattern
  task automatic verify_tx_beat(input logic [LINK_W-1:0] d, input logic [LINK_KEEP_W-1:0] k);
    int                     len;
    int                     left;
    int                     base;
    int                     n_bad;
    logic [LINK_KEEP_W-1:0] k_exp;
    len   = (tx_len_q.size() > 0) ? tx_len_q[0] : 0;
    left  = len - LINK_KEEP_W * (tx_beat - 2);
    base  = tx_frame + LINK_KEEP_W * (tx_beat - 2);
    n_bad = 0;
    if (tx_beat < 2 || left >= LINK_KEEP_W) begin
      k_exp = '1;
    end else begin
      k_exp = '0;
      for (int b = 0; b < left; b++) k_exp[b] = 1'b1;
    end
    check_value("link_tx_keep", k_exp, k);
    if (tx_beat == 1) begin
      check_value("udp length field", len + 8, {d[8*6 +: 8], d[8*7 +: 8]});  // bytes 38, 39
    end
    if (tx_beat >= 2) begin
      for (int b = 0; b < LINK_KEEP_W; b++) begin
        if (k_exp[b] && d[8*b +: 8] !== 8'((base + b) % 256)) n_bad++;
      end
      check_value("link_tx payload bytes wrong", 0, n_bad);
    end
  endtask

  // MAC stand-in that replays each accepted tx beat on rx one cycle later
  always @(posedge pkt_clk) begin : loopback
    logic [LINK_W-1:0]      d;
    logic [LINK_KEEP_W-1:0] k;
    logic                   l;
    logic                   v;
    int                     flip;
    v = arst_n && link_tx_valid && link_tx_ready;
    d = link_tx_data;
    k = link_tx_keep;
    l = link_tx_last;
    if (v) begin
      verify_tx_beat(d, k);
      if (tx_frame == corrupt_frame && corrupt_kind != CORRUPT_NONE) begin
        flip = (corrupt_kind == CORRUPT_UDP_LEN) ? OFF_UDP_LEN : 64 + corrupt_pos;
        if (flip / 32 == tx_beat) d[8*(flip%32) +: 8] = d[8*(flip%32) +: 8] ^ 8'hff;
      end
      tx_beat++;
      if (l) begin
        beat_q.push_back(tx_beat);
        if (tx_len_q.size() > 0) void'(tx_len_q.pop_front());
        tx_beat = 0;
        tx_frame++;
      end
    end
    #1;
    link_rx_valid = v;
    link_rx_data  = d;
    link_rx_keep  = k;
    link_rx_last  = l;
  end

  always @(posedge pkt_clk) begin
    if (rand_ready) begin
      #1;
      link_tx_ready = ($random(seed) % 4) != 0;  // ready about 3 cycles in 4
    end
  end

  // per-frame status against the reference
  always @(negedge pkt_clk) begin : compare_status
    status_t e;
    int      beats;
    if (arst_n && rx_done) begin
      done_cnt++;
      if (exp_q.size() == 0) begin
        n_errors++;
        $display("%s: rx_done pulsed with no frame outstanding", cur_test);
      end else begin
        e = exp_q.pop_front();
        beats = (beat_q.size() > 0) ? beat_q.pop_front() : 0;
        check_value("rx_byte_num", e.byte_num, rx_byte_num);
        check_value("rx_error", e.err, rx_error);
        check_value("rx_error_cnt", e.err_cnt, rx_error_cnt);
        check_value("link beats", e.beats, beats);
      end
    end
  end

  always @(posedge pkt_clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TB FAILED");
      $finish;
    end
  end

  initial begin
    cmd_req       = 1'b0;
    cmd_len       = '0;
    link_tx_ready = 1'b1;
    link_rx_valid = 1'b0;
    link_rx_data  = '0;
    link_rx_keep  = '0;
    link_rx_last  = 1'b0;
    rand_ready    = 1'b0;
    for (int i = 0; i < 20; i++) rand_len[i] = 1 + ($unsigned($random(seed)) % MAX_PAYLOAD);

    @(posedge arst_n);
    @(posedge pkt_clk);
    #1;
    start_test("reset");
    check_value("cmd_ack", 0, cmd_ack);
    check_value("link_tx_valid", 0, link_tx_valid);
    check_value("rx_done", 0, rx_done);
    check_value("rx_error_cnt", 0, rx_error_cnt);
    report_test();

    start_test("lengths");
    issue_frame(1, CORRUPT_NONE, 0);
    issue_frame(32, CORRUPT_NONE, 0);
    issue_frame(64, CORRUPT_NONE, 0);
    issue_frame(65, CORRUPT_NONE, 0);
    issue_frame(1024, CORRUPT_NONE, 0);
    wait_frames();
    report_test();

    start_test("backpressure");
    rand_ready = 1'b1;
    for (int i = 0; i < 20; i++) issue_frame(rand_len[i], CORRUPT_NONE, 0);
    wait_frames();
    rand_ready = 1'b0;
    @(posedge pkt_clk);
    #1;
    link_tx_ready = 1'b1;
    report_test();

    start_test("payload_corrupt");
    issue_frame(200, CORRUPT_PAYLOAD, 77);
    issue_frame(150, CORRUPT_NONE, 0);  // clean frame right after
    wait_frames();
    report_test();

    start_test("header_corrupt");
    issue_frame(300, CORRUPT_UDP_LEN, 0);
    wait_frames();
    report_test();

    start_test("handshake");
    link_tx_ready = 1'b0;
    expect_frame(1024, CORRUPT_NONE, 0);
    cmd_len = LEN_W'(1024);
    cmd_req = 1'b1;
    @(posedge pkt_clk);
    #1;
    check_value("cmd_ack after req", 1, cmd_ack);
    cmd_req = 1'b0;
    @(posedge pkt_clk);
    #1;
    check_value("cmd_ack after req drop", 0, cmd_ack);
    // second command while the stalled frame is still in the generator
    expect_frame(100, CORRUPT_NONE, 0);
    cmd_len     = LEN_W'(100);
    cmd_req     = 1'b1;
    acked_early = 1'b0;
    repeat (20) begin
      @(posedge pkt_clk);
      #1;
      if (cmd_ack) acked_early = 1'b1;
    end
    check_value("cmd_ack while busy", 0, acked_early);
    link_tx_ready = 1'b1;
    while (!cmd_ack) begin
      @(posedge pkt_clk);
      #1;
    end
    cmd_req = 1'b0;
    while (cmd_ack) begin
      @(posedge pkt_clk);
      #1;
    end
    wait_frames();
    report_test();

    repeat (50) @(posedge pkt_clk);  // let any stray rx_done show up
    check_value("rx_done count", sent_cnt, done_cnt);
    $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- sim/tb_clk_gen.sv
`timescale 1ns/1ps
module tb_clk_gen #(
  parameter int HALF_PERIOD = 5,  // ns
  parameter int RST_CYCLES  = 8
) (
  output logic pkt_clk,
  output logic arst_n
);

  initial begin
    pkt_clk = 1'b0;
    forever #(HALF_PERIOD) pkt_clk = ~pkt_clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge pkt_clk);
    #1 arst_n = 1'b1;  // release just after an edge
  end

endmodule

//--- logic/udp_loopback_top.sv
`timescale 1ns/1ps
module udp_loopback_top
  import udp_pkg::*;
(
  input  logic                   pkt_clk,
  input  logic                   arst_n,
  input  logic                   cmd_req,
  input  logic [LEN_W-1:0]       cmd_len,
  output logic                   cmd_ack,
  output logic                   link_tx_valid,
  input  logic                   link_tx_ready,
  output logic [LINK_W-1:0]      link_tx_data,
  output logic [LINK_KEEP_W-1:0] link_tx_keep,
  output logic                   link_tx_last,
  input  logic                   link_rx_valid,
  input  logic [LINK_W-1:0]      link_rx_data,
  input  logic [LINK_KEEP_W-1:0] link_rx_keep,
  input  logic                   link_rx_last,
  output logic                   rx_done,
  output logic [LEN_W-1:0]       rx_byte_num,
  output logic                   rx_error,
  output logic [LEN_W-1:0]       rx_error_cnt
);

  logic                   gen_valid, gen_ready, gen_last;
  logic [WIDE_W-1:0]      gen_data;
  logic [WIDE_KEEP_W-1:0] gen_keep;
  logic [LEN_W-1:0]       gen_byte_num;
  logic                   hdr_valid, hdr_ready, hdr_last;
  logic [WIDE_W-1:0]      hdr_data;
  logic [WIDE_KEEP_W-1:0] hdr_keep;
  logic                   fifo_valid, fifo_ready, fifo_last;
  logic [LINK_W-1:0]      fifo_data;
  logic [LINK_KEEP_W-1:0] fifo_keep;
  logic                   up_valid, up_ready, up_last;
  logic [WIDE_W-1:0]      up_data;
  logic [WIDE_KEEP_W-1:0] up_keep;

  frame_gen frame_gen_i (
    .pkt_clk(pkt_clk), .arst_n(arst_n),
    .cmd_req(cmd_req), .cmd_len(cmd_len), .cmd_ack(cmd_ack),
    .out_valid(gen_valid), .out_ready(gen_ready), .out_data(gen_data),
    .out_keep(gen_keep), .out_last(gen_last), .out_byte_num(gen_byte_num)
  );

  udp_header_insert udp_header_insert_i (
    .pkt_clk(pkt_clk), .arst_n(arst_n),
    .in_valid(gen_valid), .in_ready(gen_ready), .in_data(gen_data),
    .in_keep(gen_keep), .in_last(gen_last), .in_byte_num(gen_byte_num),
    .out_valid(hdr_valid), .out_ready(hdr_ready), .out_data(hdr_data),
    .out_keep(hdr_keep), .out_last(hdr_last)
  );

  axis_width_down axis_width_down_i (
    .pkt_clk(pkt_clk), .arst_n(arst_n),
    .in_valid(hdr_valid), .in_ready(hdr_ready), .in_data(hdr_data),
    .in_keep(hdr_keep), .in_last(hdr_last),
    .out_valid(link_tx_valid), .out_ready(link_tx_ready), .out_data(link_tx_data),
    .out_keep(link_tx_keep), .out_last(link_tx_last)
  );

  // link side has no ready, the checker drains every cycle
  stream_fifo #(.DEPTH(RX_FIFO_DEPTH)) stream_fifo_i (
    .pkt_clk(pkt_clk), .arst_n(arst_n),
    .in_valid(link_rx_valid), .in_ready(), .in_data(link_rx_data),
    .in_keep(link_rx_keep), .in_last(link_rx_last),
    .out_valid(fifo_valid), .out_ready(fifo_ready), .out_data(fifo_data),
    .out_keep(fifo_keep), .out_last(fifo_last)
  );

  axis_width_up axis_width_up_i (
    .pkt_clk(pkt_clk), .arst_n(arst_n),
    .in_valid(fifo_valid), .in_ready(fifo_ready), .in_data(fifo_data),
    .in_keep(fifo_keep), .in_last(fifo_last),
    .out_valid(up_valid), .out_ready(up_ready), .out_data(up_data),
    .out_keep(up_keep), .out_last(up_last)
  );

  udp_frame_check udp_frame_check_i (
    .pkt_clk(pkt_clk), .arst_n(arst_n),
    .in_valid(up_valid), .in_ready(up_ready), .in_data(up_data),
    .in_keep(up_keep), .in_last(up_last),
    .rx_done(rx_done), .rx_byte_num(rx_byte_num), .rx_error(rx_error),
    .rx_error_cnt(rx_error_cnt)
  );

endmodule

//--- logic/udp_frame_check.sv
`timescale 1ns/1ps
module udp_frame_check
  import udp_pkg::*;
(
  input  logic                   pkt_clk,
  input  logic                   arst_n,
  input  logic                   in_valid,
  output logic                   in_ready,
  input  logic [WIDE_W-1:0]      in_data,
  input  logic [WIDE_KEEP_W-1:0] in_keep,
  input  logic                   in_last,
  output logic                   rx_done,
  output logic [LEN_W-1:0]       rx_byte_num,
  output logic                   rx_error,
  output logic [LEN_W-1:0]       rx_error_cnt
);

  logic             hdr_seen;   // payload beats follow
  logic             hdr_err;
  logic             bad_acc;    // mismatch in an earlier payload beat
  logic [LEN_W-1:0] udp_len;
  logic [LEN_W-1:0] byte_cnt;
  logic [7:0]       frame_num;
  logic [LEN_W-1:0] hdr_udp_len;
  logic [LEN_W-1:0] total;
  logic [7:0]       base;
  logic             hdr_bad;
  logic             pay_bad;
  logic             frame_err;

  assign in_ready    = 1'b1;
  assign hdr_udp_len = swap16(in_data[8*OFF_UDP_LEN +: 16]);
  assign total       = byte_cnt + count_keep(in_keep);
  assign base        = frame_num + byte_cnt[7:0];
  assign frame_err   = bad_acc || pay_bad || hdr_err || (udp_len != total + LEN_W'(8))
                       || (total > LEN_W'(MAX_PAYLOAD));

  always_comb begin
    hdr_bad = (in_keep != '1);
    for (int k = 0; k < 6; k++) begin
      if (in_data[8*(OFF_DST_MAC+k) +: 8] != DST_MAC[8*(5-k) +: 8]) hdr_bad = 1'b1;
      if (in_data[8*(OFF_SRC_MAC+k) +: 8] != SRC_MAC[8*(5-k) +: 8]) hdr_bad = 1'b1;
    end
    if (in_data[8*OFF_ETHERTYPE +: 16] != swap16(ETHERTYPE_IPV4)) hdr_bad = 1'b1;
    if (in_data[8*OFF_IP_VER +: 8] != IP_VER_IHL) hdr_bad = 1'b1;
    if (in_data[8*OFF_IP_PROTO +: 8] != IP_PROTO_UDP) hdr_bad = 1'b1;
    if (swap16(in_data[8*OFF_IP_LEN +: 16]) != hdr_udp_len + LEN_W'(20)) hdr_bad = 1'b1;
    if (in_data[8*OFF_SRC_PORT +: 16] != swap16(UDP_SRC_PORT)) hdr_bad = 1'b1;
    if (in_data[8*OFF_DST_PORT +: 16] != swap16(UDP_DST_PORT)) hdr_bad = 1'b1;
    for (int j = HDR_BYTES; j < WIDE_KEEP_W; j++) begin
      if (in_data[8*j +: 8] != 8'h00) hdr_bad = 1'b1;  // pad must be clear
    end
  end

  always_comb begin
    pay_bad = 1'b0;
    for (int j = 0; j < WIDE_KEEP_W; j++) begin
      if (in_keep[j] && in_data[8*j +: 8] != base + 8'(j)) pay_bad = 1'b1;
    end
  end

  always_ff @(posedge pkt_clk or negedge arst_n) begin
    if (!arst_n) begin
      hdr_seen     <= 1'b0;
      hdr_err      <= 1'b0;
      bad_acc      <= 1'b0;
      udp_len      <= '0;
      byte_cnt     <= '0;
      frame_num    <= '0;
      rx_done      <= 1'b0;
      rx_byte_num  <= '0;
      rx_error     <= 1'b0;
      rx_error_cnt <= '0;
    end else begin
      rx_done <= 1'b0;
      if (in_valid) begin
        if (!hdr_seen) begin
          hdr_seen <= 1'b1;
          hdr_err  <= hdr_bad;
          udp_len  <= hdr_udp_len;
          byte_cnt <= '0;
          bad_acc  <= 1'b0;
        end else if (!in_last) begin
          byte_cnt <= total;
          bad_acc  <= bad_acc || pay_bad;
        end else begin
          hdr_seen     <= 1'b0;
          rx_done      <= 1'b1;
          rx_byte_num  <= total;
          rx_error     <= frame_err;
          rx_error_cnt <= rx_error_cnt + LEN_W'(frame_err);
          frame_num    <= frame_num + 8'd1;
        end
      end
    end
  end

endmodule

//--- logic/axis_width_up.sv
`timescale 1ns/1ps
module axis_width_up
  import udp_pkg::*;
(
  input  logic                   pkt_clk,
  input  logic                   arst_n,
  input  logic                   in_valid,
  output logic                   in_ready,
  input  logic [LINK_W-1:0]      in_data,
  input  logic [LINK_KEEP_W-1:0] in_keep,
  input  logic                   in_last,
  output logic                   out_valid,
  input  logic                   out_ready,
  output logic [WIDE_W-1:0]      out_data,
  output logic [WIDE_KEEP_W-1:0] out_keep,
  output logic                   out_last
);

  logic                   low_valid;  // low half waiting for its partner
  logic [LINK_W-1:0]      low_data;
  logic [LINK_KEEP_W-1:0] low_keep;
  logic                   take;

  assign in_ready = !out_valid || out_ready;  // stall while wide beat is stuck
  assign take     = in_valid && in_ready;

  always_ff @(posedge pkt_clk or negedge arst_n) begin
    if (!arst_n) begin
      low_valid <= 1'b0;
      out_valid <= 1'b0;
    end else if (take) begin
      out_valid <= low_valid || in_last;
      low_valid <= !low_valid && !in_last;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge pkt_clk) begin
    if (take) begin
      if (!low_valid) begin
        low_data <= in_data;
        low_keep <= in_keep;
      end
      // early last in the low slot leaves the upper half empty
      out_data <= low_valid ? {in_data, low_data} : {{LINK_W{1'b0}}, in_data};
      out_keep <= low_valid ? {in_keep, low_keep} : {{LINK_KEEP_W{1'b0}}, in_keep};
      out_last <= in_last;
    end
  end

endmodule

//--- logic/stream_fifo.sv
`timescale 1ns/1ps
module stream_fifo
  import udp_pkg::*;
#(
  parameter int DEPTH = 16
) (
  input  logic                   pkt_clk,
  input  logic                   arst_n,
  input  logic                   in_valid,
  output logic                   in_ready,
  input  logic [LINK_W-1:0]      in_data,
  input  logic [LINK_KEEP_W-1:0] in_keep,
  input  logic                   in_last,
  output logic                   out_valid,
  input  logic                   out_ready,
  output logic [LINK_W-1:0]      out_data,
  output logic [LINK_KEEP_W-1:0] out_keep,
  output logic                   out_last
);

  logic [LINK_W-1:0]          mem_data [DEPTH];
  logic [LINK_KEEP_W-1:0]     mem_keep [DEPTH];
  logic                       mem_last [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wptr;
  logic [$clog2(DEPTH)-1:0]   rptr;
  logic [$clog2(DEPTH+1)-1:0] count;  // entries held
  logic                       wr_en;
  logic                       rd_en;

  assign in_ready  = (count != DEPTH);
  assign out_valid = (count != 0);
  assign wr_en     = in_valid && in_ready;
  assign rd_en     = out_valid && out_ready;
  assign out_data  = mem_data[rptr];
  assign out_keep  = mem_keep[rptr];
  assign out_last  = mem_last[rptr];

  always_ff @(posedge pkt_clk or negedge arst_n) begin
    if (!arst_n) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (wr_en) begin
        wptr <= (wptr == DEPTH - 1) ? '0 : wptr + 1'b1;
      end
      if (rd_en) begin
        rptr <= (rptr == DEPTH - 1) ? '0 : rptr + 1'b1;
      end
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (rd_en && !wr_en) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge pkt_clk) begin
    if (wr_en) begin
      mem_data[wptr] <= in_data;
      mem_keep[wptr] <= in_keep;
      mem_last[wptr] <= in_last;
    end
  end

endmodule

//--- logic/axis_width_down.sv
`timescale 1ns/1ps
module axis_width_down
  import udp_pkg::*;
(
  input  logic                   pkt_clk,
  input  logic                   arst_n,
  input  logic                   in_valid,
  output logic                   in_ready,
  input  logic [WIDE_W-1:0]      in_data,
  input  logic [WIDE_KEEP_W-1:0] in_keep,
  input  logic                   in_last,
  output logic                   out_valid,
  input  logic                   out_ready,
  output logic [LINK_W-1:0]      out_data,
  output logic [LINK_KEEP_W-1:0] out_keep,
  output logic                   out_last
);

  logic                   hold_valid;
  logic                   upper;       // low half already sent
  logic [WIDE_W-1:0]      hold_data;
  logic [WIDE_KEEP_W-1:0] hold_keep;
  logic                   hold_last;
  logic                   two_halves;
  logic                   final_half;

  assign two_halves = count_keep(hold_keep) > LEN_W'(LINK_KEEP_W);
  assign final_half = upper || !two_halves;
  assign out_valid  = hold_valid;
  assign out_data   = upper ? hold_data[WIDE_W-1 -: LINK_W] : hold_data[LINK_W-1:0];
  assign out_keep   = upper ? hold_keep[WIDE_KEEP_W-1 -: LINK_KEEP_W]
                            : hold_keep[LINK_KEEP_W-1:0];
  assign out_last   = hold_last && final_half;
  assign in_ready   = !hold_valid || (out_ready && final_half);

  always_ff @(posedge pkt_clk or negedge arst_n) begin
    if (!arst_n) begin
      hold_valid <= 1'b0;
      upper      <= 1'b0;
    end else if (in_valid && in_ready) begin
      hold_valid <= 1'b1;
      upper      <= 1'b0;
    end else if (hold_valid && out_ready) begin
      hold_valid <= !final_half;
      upper      <= !final_half;
    end
  end

  always_ff @(posedge pkt_clk) begin
    if (in_valid && in_ready) begin
      hold_data <= in_data;
      hold_keep <= in_keep;
      hold_last <= in_last;
    end
  end

endmodule

//--- logic/udp_header_insert.sv
`timescale 1ns/1ps
module udp_header_insert
  import udp_pkg::*;
(
  input  logic                   pkt_clk,
  input  logic                   arst_n,
  input  logic                   in_valid,
  output logic                   in_ready,
  input  logic [WIDE_W-1:0]      in_data,
  input  logic [WIDE_KEEP_W-1:0] in_keep,
  input  logic                   in_last,
  input  logic [LEN_W-1:0]       in_byte_num,
  output logic                   out_valid,
  input  logic                   out_ready,
  output logic [WIDE_W-1:0]      out_data,
  output logic [WIDE_KEEP_W-1:0] out_keep,
  output logic                   out_last
);

  logic              in_frame;  // header already sent for this frame
  logic              out_free;
  logic [WIDE_W-1:0] hdr;

  assign out_free = !out_valid || out_ready;
  assign in_ready = in_frame && out_free;  // header beat holds the payload back

  always_comb begin
    hdr = '0;
    for (int k = 0; k < 6; k++) begin
      hdr[8*(OFF_DST_MAC+k) +: 8] = DST_MAC[8*(5-k) +: 8];
      hdr[8*(OFF_SRC_MAC+k) +: 8] = SRC_MAC[8*(5-k) +: 8];
    end
    hdr[8*OFF_ETHERTYPE +: 16] = swap16(ETHERTYPE_IPV4);
    hdr[8*OFF_IP_VER +: 8]     = IP_VER_IHL;
    hdr[8*OFF_IP_LEN +: 16]    = swap16(in_byte_num + LEN_W'(28));  // ip + udp headers
    hdr[8*OFF_IP_PROTO +: 8]   = IP_PROTO_UDP;
    hdr[8*OFF_SRC_PORT +: 16]  = swap16(UDP_SRC_PORT);
    hdr[8*OFF_DST_PORT +: 16]  = swap16(UDP_DST_PORT);
    hdr[8*OFF_UDP_LEN +: 16]   = swap16(in_byte_num + LEN_W'(8));
  end

  always_ff @(posedge pkt_clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      in_frame  <= 1'b0;
    end else if (out_free) begin
      out_valid <= in_valid;
      if (in_valid) begin
        in_frame <= !(in_frame && in_last);  // header opens, last closes
      end
    end
  end

  always_ff @(posedge pkt_clk) begin
    if (out_free && in_valid) begin
      out_data <= in_frame ? in_data : hdr;
      out_keep <= in_frame ? in_keep : '1;
      out_last <= in_frame && in_last;
    end
  end

endmodule

//--- logic/frame_gen.sv
`timescale 1ns/1ps
module frame_gen
  import udp_pkg::*;
(
  input  logic                   pkt_clk,
  input  logic                   arst_n,
  input  logic                   cmd_req,
  input  logic [LEN_W-1:0]       cmd_len,
  output logic                   cmd_ack,
  output logic                   out_valid,
  input  logic                   out_ready,
  output logic [WIDE_W-1:0]      out_data,
  output logic [WIDE_KEEP_W-1:0] out_keep,
  output logic                   out_last,
  output logic [LEN_W-1:0]       out_byte_num
);

  typedef enum logic [1:0] {S_IDLE, S_ACK, S_SEND} state_t;

  state_t           state;
  logic [LEN_W-1:0] len_q;
  logic [LEN_W-1:0] offset;     // payload bytes already issued
  logic [LEN_W-1:0] remain;
  logic [7:0]       frame_num;
  logic [7:0]       base;       // pattern value of byte 0 of this beat

  assign remain       = len_q - offset;
  assign base         = frame_num + offset[7:0];
  assign out_valid    = (state == S_SEND);
  assign out_last     = (remain <= LEN_W'(WIDE_KEEP_W));
  assign out_keep     = out_last ? keep_from_count(remain) : '1;
  assign out_byte_num = len_q;

  always_comb begin
    for (int j = 0; j < WIDE_KEEP_W; j++) begin
      out_data[8*j +: 8] = base + 8'(j);
    end
  end

  always_ff @(posedge pkt_clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= S_IDLE;
      cmd_ack   <= 1'b0;
      len_q     <= '0;
      offset    <= '0;
      frame_num <= '0;
    end else begin
      if (cmd_ack && !cmd_req) begin
        cmd_ack <= 1'b0;  // second half of the handshake
      end
      case (state)
        S_IDLE: begin
          if (cmd_req && !cmd_ack) begin
            len_q   <= cmd_len;
            offset  <= '0;
            cmd_ack <= 1'b1;
            state   <= S_ACK;
          end
        end
        S_ACK: state <= S_SEND;
        S_SEND: begin
          if (out_ready) begin
            if (out_last) begin
              frame_num <= frame_num + 8'd1;
              state     <= S_IDLE;
            end else begin
              offset <= offset + LEN_W'(WIDE_KEEP_W);
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

//--- logic/udp_pkg.sv
package udp_pkg;

  localparam int WIDE_W        = 512;
  localparam int WIDE_KEEP_W   = WIDE_W / 8;
  localparam int LINK_W        = 256;
  localparam int LINK_KEEP_W   = LINK_W / 8;
  localparam int LEN_W         = 16;
  localparam int MAX_PAYLOAD   = 1024;  // bytes
  localparam int HDR_BYTES     = 42;    // real header, rest of beat is pad
  localparam int RX_FIFO_DEPTH = 32;    // link beats

  localparam logic [47:0] DST_MAC        = 48'h02_0a_35_00_00_02;
  localparam logic [47:0] SRC_MAC        = 48'h02_0a_35_00_00_01;
  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
  localparam logic [15:0] UDP_SRC_PORT   = 16'd4660;
  localparam logic [15:0] UDP_DST_PORT   = 16'd4661;
  localparam logic [7:0]  IP_VER_IHL     = 8'h45;
  localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;

  // byte offsets inside the header beat, fields are big endian
  localparam int OFF_DST_MAC   = 0;
  localparam int OFF_SRC_MAC   = 6;
  localparam int OFF_ETHERTYPE = 12;
  localparam int OFF_IP_VER    = 14;
  localparam int OFF_IP_LEN    = 16;
  localparam int OFF_IP_PROTO  = 23;
  localparam int OFF_SRC_PORT  = 34;
  localparam int OFF_DST_PORT  = 36;
  localparam int OFF_UDP_LEN   = 38;

  function automatic logic [WIDE_KEEP_W-1:0] keep_from_count(input logic [LEN_W-1:0] cnt);
    logic [WIDE_KEEP_W-1:0] k;
    for (int i = 0; i < WIDE_KEEP_W; i++) begin
      k[i] = (LEN_W'(i) < cnt);
    end
    return k;
  endfunction

  function automatic logic [LEN_W-1:0] count_keep(input logic [WIDE_KEEP_W-1:0] keep);
    logic [LEN_W-1:0] n;
    n = '0;
    for (int i = 0; i < WIDE_KEEP_W; i++) begin
      n = n + LEN_W'(keep[i]);
    end
    return n;
  endfunction

  // byte swap so a 16-bit value lands in wire order
  function automatic logic [15:0] swap16(input logic [15:0] v);
    return {v[7:0], v[15:8]};
  endfunction

endpackage
